// File: run.sh
#!/bin/sh
# build and run the rvCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tbRvCore -o simTbRvCore
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/simTbRvCore > sim.log 2>&1
runStatus=$?
cat sim.log

if grep -q "Checks failed" sim.log; then
    exit 1
fi

if [ $runStatus -ne 0 ]; then
    echo "simulation exited with status $runStatus"
    exit 1
fi

exit 0

// File: sim/tbRvCore.sv
`timescale 1ns/1ps

module tbRvCore import rvPkg::*; ();

    localparam int rowMax = 64;

    logic            clk;
    logic            arstN;
    logic [xlen-1:0] instr;
    logic [xlen-1:0] memRdata;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] memAddr;
    logic [xlen-1:0] memWdata;
    logic            memWe;

    logic [xlen-1:0] imem [64];
    logic [xlen-1:0] dmem [64];

    // program table, one row per executed instruction
    logic [xlen-1:0] rowInstr [rowMax];
    logic [xlen-1:0] rowPc    [rowMax];
    logic            rowSt    [rowMax];
    logic [xlen-1:0] rowAddr  [rowMax];
    logic [xlen-1:0] rowData  [rowMax];
    int              rowCount;
    int              errors;
    int              cycles;

    rvCore #(
        .regCount (32)
    ) i_rvCore (
        .clk      (clk),
        .arstN    (arstN),
        .instr    (instr),
        .memRdata (memRdata),
        .pc       (pc),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memWe    (memWe)
    );

    assign instr    = imem[pc[7:2]];
    assign memRdata = dmem[memAddr[7:2]];

    always #10 clk = ~clk;

    always @(posedge clk) begin
        if (arstN && memWe) begin
            dmem[memAddr[7:2]] <= memWdata;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 2 * rowCount + 10) begin
            $display("timeout, the program did not reach its last row");
            $display("Checks failed");
            $fatal(1);
        end
    end

    function automatic logic [31:0] rTypeWord(input int f7, input int rs2, input int rs1,
                                              input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opcOp};
    endfunction

    function automatic logic [31:0] iTypeWord(input int imm, input int rs1, input int f3,
                                              input int rd, input opcodeT op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] storeWord(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opcStore};
    endfunction

    function automatic logic [31:0] branchWord(input int imm, input int rs2, input int rs1,
                                               input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], opcBranch};
    endfunction

    function automatic logic [31:0] upperWord(input int imm, input int rd, input opcodeT op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] jalWord(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opcJal};
    endfunction

    task automatic addRow(input logic [xlen-1:0] word, input logic [xlen-1:0] at,
                          input logic st, input logic [xlen-1:0] addr,
                          input logic [xlen-1:0] data);
        rowInstr[rowCount] = word;
        rowPc[rowCount]    = at;
        rowSt[rowCount]    = st;
        rowAddr[rowCount]  = addr;
        rowData[rowCount]  = data;
        rowCount++;
    endtask

    task automatic reportFail();
        errors++;
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic checkPc(input logic [xlen-1:0] got, input logic [xlen-1:0] exp);
        if (got !== exp) begin
            $display("FAIL pc: got %h, expected %h", got, exp);
            reportFail();
        end
    endtask

    task automatic checkStore(input logic [xlen-1:0] gotAddr, input logic [xlen-1:0] expAddr,
                              input logic [xlen-1:0] gotData, input logic [xlen-1:0] expData);
        if (gotAddr !== expAddr) begin
            $display("FAIL memAddr: got %h, expected %h", gotAddr, expAddr);
            reportFail();
        end
        if (gotData !== expData) begin
            $display("FAIL memWdata: got %h, expected %h", gotData, expData);
            reportFail();
        end
    endtask

    task automatic buildProgram();
        addRow(iTypeWord(100, 0, 0, 1, opcOpImm), 0, 0, 0, 0);   // x1 = 100
        addRow(iTypeWord(-7, 0, 0, 2, opcOpImm), 4, 0, 0, 0);    // x2 = -7
        addRow(upperWord(32'h12345, 3, opcLui), 8, 0, 0, 0);
        addRow(storeWord(0, 3, 0), 12, 1, 0, 32'h12345000);
        addRow(rTypeWord(0, 2, 1, 0, 4), 16, 0, 0, 0);          // add
        addRow(storeWord(4, 4, 0), 20, 1, 4, 32'h0000005d);
        addRow(rTypeWord(32, 2, 1, 0, 5), 24, 0, 0, 0);         // sub
        addRow(storeWord(8, 5, 0), 28, 1, 8, 32'h0000006b);
        addRow(rTypeWord(0, 2, 1, 7, 6), 32, 0, 0, 0);          // and
        addRow(storeWord(12, 6, 0), 36, 1, 12, 32'h00000060);
        addRow(rTypeWord(0, 2, 1, 6, 7), 40, 0, 0, 0);          // or
        addRow(storeWord(16, 7, 0), 44, 1, 16, 32'hfffffffd);
        addRow(iTypeWord(15, 2, 4, 8, opcOpImm), 48, 0, 0, 0);   // xori
        addRow(storeWord(20, 8, 0), 52, 1, 20, 32'hfffffff6);
        addRow(iTypeWord(4, 1, 1, 9, opcOpImm), 56, 0, 0, 0);    // slli
        addRow(storeWord(24, 9, 0), 60, 1, 24, 32'h00000640);
        addRow(iTypeWord(32'h401, 2, 5, 10, opcOpImm), 64, 0, 0, 0); // srai
        addRow(storeWord(28, 10, 0), 68, 1, 28, 32'hfffffffc);
        addRow(iTypeWord(28, 2, 5, 11, opcOpImm), 72, 0, 0, 0);  // srli
        addRow(storeWord(32, 11, 0), 76, 1, 32, 32'h0000000f);
        addRow(rTypeWord(0, 1, 2, 2, 12), 80, 0, 0, 0);         // slt, signed -7 < 100
        addRow(storeWord(36, 12, 0), 84, 1, 36, 32'h00000001);
        addRow(rTypeWord(0, 1, 2, 3, 13), 88, 0, 0, 0);         // sltu, unsigned not less
        addRow(storeWord(40, 13, 0), 92, 1, 40, 32'h00000000);
        addRow(upperWord(1, 15, opcAuipc), 96, 0, 0, 0);
        addRow(storeWord(44, 15, 0), 100, 1, 44, 32'h00001060);
        addRow(storeWord(48, 1, 0), 104, 1, 48, 32'h00000064);
        addRow(iTypeWord(48, 0, 2, 16, opcLoad), 108, 0, 0, 0);
        addRow(storeWord(52, 16, 0), 112, 1, 52, 32'h00000064);
        addRow(branchWord(8, 1, 1, 0), 116, 0, 0, 0);           // beq taken
        addRow(branchWord(8, 2, 1, 0), 124, 0, 0, 0);           // beq not taken
        addRow(branchWord(8, 2, 1, 1), 128, 0, 0, 0);           // bne taken
        addRow(branchWord(8, 1, 1, 1), 136, 0, 0, 0);
        addRow(branchWord(8, 1, 2, 4), 140, 0, 0, 0);           // blt taken
        addRow(branchWord(8, 2, 1, 4), 148, 0, 0, 0);
        addRow(branchWord(8, 2, 1, 5), 152, 0, 0, 0);           // bge taken
        addRow(branchWord(8, 1, 2, 5), 160, 0, 0, 0);
        addRow(branchWord(8, 2, 1, 6), 164, 0, 0, 0);           // bltu taken
        addRow(branchWord(8, 1, 2, 6), 172, 0, 0, 0);
        addRow(branchWord(8, 1, 2, 7), 176, 0, 0, 0);           // bgeu taken
        addRow(branchWord(8, 2, 1, 7), 184, 0, 0, 0);
        addRow(jalWord(12, 17), 188, 0, 0, 0);
        addRow(storeWord(56, 17, 0), 200, 1, 56, 32'h000000c0);
        addRow(iTypeWord(221, 0, 0, 18, opcOpImm), 204, 0, 0, 0); // odd target
        addRow(iTypeWord(0, 18, 0, 19, opcJalr), 208, 0, 0, 0);
        addRow(storeWord(60, 19, 0), 220, 1, 60, 32'h000000d4);
        addRow(rTypeWord(32, 1, 2, 5, 20), 224, 0, 0, 0);       // sra by x1 low bits, 4
        addRow(storeWord(64, 20, 0), 228, 1, 64, 32'hffffffff);
        addRow(iTypeWord(5, 2, 2, 21, opcOpImm), 232, 0, 0, 0);  // slti, -7 < 5
        addRow(storeWord(68, 21, 0), 236, 1, 68, 32'h00000001);
        addRow(iTypeWord(-1, 1, 3, 22, opcOpImm), 240, 0, 0, 0); // sltiu, 100 below all ones
        addRow(storeWord(72, 22, 0), 244, 1, 72, 32'h00000001);
        addRow(jalWord(0, 0), 248, 0, 0, 0);                    // park
    endtask

    initial begin
        clk      = 1'b0;
        arstN    = 1'b0;
        rowCount = 0;
        errors   = 0;
        cycles   = 0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = 32'h00000013; // nop in skipped slots
            dmem[i] = 32'hd0000000 | (i * 32'h00010001);
        end
        buildProgram();
        for (int i = 0; i < rowCount; i++) begin
            imem[rowPc[i][7:2]] = rowInstr[i];
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        checkPc(pc, 0);
        if (memWe !== 1'b0) begin
            $display("memWe is set right after reset");
            reportFail();
        end
        arstN = 1'b1;
        for (int i = 0; i < rowCount; i++) begin
            checkPc(pc, rowPc[i]);
            if (memWe === 1'b1 && !rowSt[i]) begin
                $display("unexpected store at pc %h", pc);
                reportFail();
            end
            if (rowSt[i]) begin
                if (memWe !== 1'b1) begin
                    $display("store missing at pc %h", pc);
                    reportFail();
                end
                checkStore(memAddr, rowAddr[i], memWdata, rowData[i]);
            end
            @(negedge clk);
        end
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: sources.f
verilog/rvPkg.sv
verilog/ctrlIf.sv
verilog/mainDecoder.sv
verilog/aluDecoder.sv
verilog/controlUnit.sv
verilog/alu.sv
verilog/regFile.sv
verilog/immExtend.sv
verilog/rvCore.sv
sim/tbRvCore.sv

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu import rvPkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  aluCtrlT         aluControl,
    output logic [xlen-1:0] result,
    output logic            zero,
    output logic            neg,
    output logic            carry,
    output logic            overflow
);

    localparam int shW = $clog2(xlen);

    logic            isSub;
    logic [xlen-1:0] bOp;
    logic [xlen-1:0] sum;
    logic [shW-1:0]  shamt;

    assign isSub = aluControl inside {aluSub, aluSlt, aluSltu};
    assign bOp   = isSub ? ~b : b;
    assign {carry, sum} = {1'b0, a} + {1'b0, bOp} + (xlen+1)'(isSub);
    assign overflow = (a[xlen-1] == bOp[xlen-1]) && (sum[xlen-1] != a[xlen-1]);
    assign shamt = b[shW-1:0];

    always_comb begin
        case (aluControl)
            aluAdd, aluSub: result = sum;
            aluAnd:   result = a & b;
            aluOr:    result = a | b;
            aluXor:   result = a ^ b;
            aluSll:   result = a << shamt;
            aluSrl:   result = a >> shamt;
            aluSra:   result = $unsigned($signed(a) >>> shamt);
            aluSlt:   result = {{(xlen-1){1'b0}}, sum[xlen-1] ^ overflow};
            aluSltu:  result = {{(xlen-1){1'b0}}, ~carry}; // borrow
            aluPassB: result = b;
            default:  result = sum;
        endcase
    end

    assign zero = ~|result;
    assign neg  = result[xlen-1];

    // beq and bne rely on zero meaning equal operands
    always_comb begin
        assert final (aluControl != aluSub || zero == (a == b))
            else $error("zero flag %b for %h - %h", zero, a, b);
    end

endmodule

// File: verilog/aluDecoder.sv
`timescale 1ns/1ps

module aluDecoder import rvPkg::*; (
    input  aluOpT       aluOp,
    input  logic [2:0]  funct3,
    input  logic        funct7b5,
    input  logic        opB5,
    output aluCtrlT     aluControl
);

    logic subSel;

    // only register-register add can become sub, addi keeps imm bit 10
    assign subSel = funct7b5 && opB5;

    always_comb begin
        case (aluOp)
            opAddOnly:   aluControl = aluAdd;
            opBranchSub: aluControl = aluSub; // compare
            opLuiPass:   aluControl = aluPassB;
            opRType, opIType: begin
                case (funct3)
                    3'b000:  aluControl = subSel ? aluSub : aluAdd;
                    3'b001:  aluControl = aluSll;
                    3'b010:  aluControl = aluSlt;
                    3'b011:  aluControl = aluSltu;
                    3'b100:  aluControl = aluXor;
                    3'b101:  aluControl = funct7b5 ? aluSra : aluSrl;
                    3'b110:  aluControl = aluOr;
                    default: aluControl = aluAnd;
                endcase
            end
            default:     aluControl = aluAdd;
        endcase
    end

endmodule

// File: verilog/controlUnit.sv
`timescale 1ns/1ps

module controlUnit import rvPkg::*; (
    input  opcodeT     op,
    input  logic [2:0] funct3,
    input  logic       funct7b5,
    input  logic       zero,
    input  logic       neg,
    input  logic       carry,
    input  logic       overflow,
    ctrlIf.ctrl        ctl
);

    logic    branch;
    logic    jump;
    logic    pcSrc;
    logic    signedLess;
    aluOpT   aluOp;
    aluCtrlT aluControl;

    mainDecoder i_mainDecoder (
        .op     (op),
        .branch (branch),
        .jump   (jump),
        .ctl    (ctl),
        .aluOp  (aluOp)
    );

    aluDecoder i_aluDecoder (
        .aluOp      (aluOp),
        .funct3     (funct3),
        .funct7b5   (funct7b5),
        .opB5       (op[5]),
        .aluControl (aluControl)
    );

    assign signedLess = neg ^ overflow; // from rs1 - rs2

    always_comb begin
        pcSrc = 1'b0;
        if (jump) begin
            pcSrc = 1'b1;
        end else if (branch) begin
            case (funct3)
                3'b000:  pcSrc = zero;        // beq
                3'b001:  pcSrc = ~zero;       // bne
                3'b100:  pcSrc = signedLess;  // blt
                3'b101:  pcSrc = ~signedLess; // bge
                3'b110:  pcSrc = ~carry;      // bltu, borrow
                3'b111:  pcSrc = carry;       // bgeu
                default: pcSrc = 1'b0;
            endcase
        end
    end

    assign ctl.pcSrc      = pcSrc;
    assign ctl.aluControl = aluControl;

    // a redirect must come from a control-flow opcode
    always_comb begin
        assert final (!pcSrc || (op inside {opcBranch, opcJal, opcJalr}))
            else $error("pcSrc set for opcode %b", op);
    end

endmodule

// File: verilog/ctrlIf.sv
`timescale 1ns/1ps

interface ctrlIf import rvPkg::*; ();

    logic      pcSrc;
    logic      pcFromAlu; // jalr takes its target from the alu
    resultSrcT resultSrc;
    logic      memWrite;
    aluCtrlT   aluControl;
    logic      aluSrc;    // operand b from immediate
    logic      aluASrcPc; // auipc
    immSrcT    immSrc;
    logic      regWrite;

    modport ctrl (
        output pcSrc, pcFromAlu, resultSrc, memWrite, aluControl,
               aluSrc, aluASrcPc, immSrc, regWrite
    );

    modport dp (
        input pcSrc, pcFromAlu, resultSrc, memWrite, aluControl,
              aluSrc, aluASrcPc, immSrc, regWrite
    );

endinterface

// File: verilog/immExtend.sv
`timescale 1ns/1ps

module immExtend import rvPkg::*; (
    input  logic [xlen-1:0] instr,
    input  immSrcT          immSrc,
    output logic [xlen-1:0] imm
);

    always_comb begin
        case (immSrc)
            immI: imm = {{20{instr[31]}}, instr[31:20]};
            immS: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            immJ: imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            immU: imm = {instr[31:12], 12'b0}; // upper, no sign fill needed
            default: imm = '0;
        endcase
    end

endmodule

// File: verilog/mainDecoder.sv
`timescale 1ns/1ps

module mainDecoder import rvPkg::*; (
    input  opcodeT op,
    output logic   branch,
    output logic   jump,
    ctrlIf.ctrl    ctl,
    output aluOpT  aluOp
);

    always_comb begin
        branch        = 1'b0;
        jump          = 1'b0;
        aluOp         = opAddOnly;
        ctl.regWrite  = 1'b0;
        ctl.memWrite  = 1'b0;
        ctl.aluSrc    = 1'b0;
        ctl.aluASrcPc = 1'b0;
        ctl.pcFromAlu = 1'b0;
        ctl.immSrc    = immI;
        ctl.resultSrc = resAlu;
        case (op)
            opcOp: begin
                ctl.regWrite = 1'b1;
                aluOp        = opRType;
            end
            opcOpImm: begin
                ctl.regWrite = 1'b1;
                ctl.aluSrc   = 1'b1;
                aluOp        = opIType;
            end
            opcLoad: begin
                ctl.regWrite  = 1'b1;
                ctl.aluSrc    = 1'b1;
                ctl.resultSrc = resMem;
            end
            opcStore: begin
                ctl.memWrite = 1'b1;
                ctl.aluSrc   = 1'b1;
                ctl.immSrc   = immS;
            end
            opcBranch: begin
                branch     = 1'b1;
                ctl.immSrc = immB;
                aluOp      = opBranchSub;
            end
            opcJal: begin
                jump          = 1'b1;
                ctl.regWrite  = 1'b1;
                ctl.immSrc    = immJ;
                ctl.resultSrc = resPcPlus4;
            end
            opcJalr: begin
                jump          = 1'b1;
                ctl.regWrite  = 1'b1;
                ctl.aluSrc    = 1'b1;
                ctl.pcFromAlu = 1'b1;
                ctl.resultSrc = resPcPlus4; // link
            end
            opcLui: begin
                ctl.regWrite = 1'b1;
                ctl.aluSrc   = 1'b1;
                ctl.immSrc   = immU;
                aluOp        = opLuiPass;
            end
            opcAuipc: begin
                ctl.regWrite  = 1'b1;
                ctl.aluSrc    = 1'b1;
                ctl.aluASrcPc = 1'b1;
                ctl.immSrc    = immU;
            end
            default: ; // unknown opcode writes nothing
        endcase
    end

endmodule

// File: verilog/regFile.sv
`timescale 1ns/1ps

module regFile import rvPkg::*; #(
    parameter int regCount = 32
) (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic                        we,
    input  logic [$clog2(regCount)-1:0] rs1,
    input  logic [$clog2(regCount)-1:0] rs2,
    input  logic [$clog2(regCount)-1:0] rd,
    input  logic [xlen-1:0]             wd,
    output logic [xlen-1:0]             rd1,
    output logic [xlen-1:0]             rd2
);

    logic [xlen-1:0] regs [regCount];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= wd;
        end
    end

    assign rd1 = (rs1 == '0) ? '0 : regs[rs1]; // x0 reads zero
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

    x0NeverWritten: assert property (
        @(posedge clk) disable iff (!arstN) regs[0] == '0
    ) else $error("entry 0 holds %h", regs[0]);

endmodule

// File: verilog/rvCore.sv
`timescale 1ns/1ps

module rvCore import rvPkg::*; #(
    parameter int regCount = 32
) (
    input  logic            clk,
    input  logic            arstN,
    input  logic [xlen-1:0] instr,
    input  logic [xlen-1:0] memRdata,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] memAddr,
    output logic [xlen-1:0] memWdata,
    output logic            memWe
);

    localparam int regIdxW = $clog2(regCount);

    logic [xlen-1:0] pcNext;
    logic [xlen-1:0] pcPlus4;
    logic [xlen-1:0] pcTarget;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rd1;
    logic [xlen-1:0] rd2;
    logic [xlen-1:0] srcA;
    logic [xlen-1:0] srcB;
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] result;
    logic            zero;
    logic            neg;
    logic            carry;
    logic            overflow;

    ctrlIf ctl ();

    controlUnit i_controlUnit (
        .op       (instr[6:0]),
        .funct3   (instr[14:12]),
        .funct7b5 (instr[30]),
        .zero     (zero),
        .neg      (neg),
        .carry    (carry),
        .overflow (overflow),
        .ctl      (ctl.ctrl)
    );

    regFile #(
        .regCount (regCount)
    ) i_regFile (
        .clk   (clk),
        .arstN (arstN),
        .we    (ctl.regWrite),
        .rs1   (instr[15 +: regIdxW]),
        .rs2   (instr[20 +: regIdxW]),
        .rd    (instr[7 +: regIdxW]),
        .wd    (result),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    immExtend i_immExtend (
        .instr  (instr),
        .immSrc (ctl.immSrc),
        .imm    (imm)
    );

    assign srcA = ctl.aluASrcPc ? pc : rd1; // auipc
    assign srcB = ctl.aluSrc ? imm : rd2;

    alu i_alu (
        .a          (srcA),
        .b          (srcB),
        .aluControl (ctl.aluControl),
        .result     (aluResult),
        .zero       (zero),
        .neg        (neg),
        .carry      (carry),
        .overflow   (overflow)
    );

    always_comb begin
        case (ctl.resultSrc)
            resMem:     result = memRdata;
            resPcPlus4: result = pcPlus4; // link value
            default:    result = aluResult;
        endcase
    end

    assign pcPlus4  = pc + xlen'(4);
    assign pcTarget = pc + imm;

    always_comb begin
        if (!ctl.pcSrc) begin
            pcNext = pcPlus4;
        end else if (ctl.pcFromAlu) begin
            pcNext = {aluResult[xlen-1:1], 1'b0}; // jalr clears bit 0
        end else begin
            pcNext = pcTarget;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    assign memAddr  = aluResult;
    assign memWdata = rd2;
    assign memWe    = ctl.memWrite;

endmodule

// File: verilog/rvPkg.sv
package rvPkg;

    localparam int xlen = 32;

    typedef logic [6:0] opcodeT;

    localparam opcodeT opcOp     = 7'b0110011;
    localparam opcodeT opcOpImm  = 7'b0010011;
    localparam opcodeT opcLoad   = 7'b0000011;
    localparam opcodeT opcStore  = 7'b0100011;
    localparam opcodeT opcBranch = 7'b1100011;
    localparam opcodeT opcJal    = 7'b1101111;
    localparam opcodeT opcJalr   = 7'b1100111;
    localparam opcodeT opcLui    = 7'b0110111;
    localparam opcodeT opcAuipc  = 7'b0010111;

    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluAnd   = 4'd2,
        aluOr    = 4'd3,
        aluXor   = 4'd4,
        aluSll   = 4'd5,
        aluSrl   = 4'd6,
        aluSra   = 4'd7,
        aluSlt   = 4'd8,
        aluSltu  = 4'd9,
        aluPassB = 4'd10 // lui
    } aluCtrlT;

    typedef enum logic [2:0] {
        immI = 3'd0,
        immS = 3'd1,
        immB = 3'd2,
        immJ = 3'd3,
        immU = 3'd4
    } immSrcT;

    typedef enum logic [2:0] {
        opAddOnly   = 3'd0, // address and pc arithmetic
        opBranchSub = 3'd1,
        opRType     = 3'd2,
        opIType     = 3'd3,
        opLuiPass   = 3'd4
    } aluOpT;

    typedef enum logic [1:0] {
        resAlu     = 2'd0,
        resMem     = 2'd1,
        resPcPlus4 = 2'd2
    } resultSrcT;

endpackage
